// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= issue_stage_tb
FLIST ?= flist.f
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR ?= obj_dir
PASS_MSG = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

# The run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+include
rtl/issue_pkg.sv
rtl/instr_decode.sv
rtl/issue_buffer.sv
rtl/issue_stage.sv
tests/issue_stage_tb.sv

// ==== include/issue_macros.svh ====
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Issue buffer entries must be a power of two and at least 8
`define ISSUE_DEPTH 8

// Integer register index width
`define REG_ADDR_WIDTH 5

// Raw instruction width
`define INSTR_WIDTH 32

// Width of pc and immediate
`define XLEN 32

`endif

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module instr_decode (
  input  issue_pkg::fetch_slot_t fetch,
  output issue_pkg::instr_rec_t  rec
);

  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam issue_pkg::word_t mret_word = 32'h30200073;
  localparam issue_pkg::word_t wfi_word = 32'h10500073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic sign;
  issue_pkg::reg_addr_t rd;
  issue_pkg::op_flags_t op;

  always_comb begin
    opcode = fetch.instr[6:0];
    funct3 = fetch.instr[14:12];
    funct7 = fetch.instr[31:25];
    sign = fetch.instr[`INSTR_WIDTH-1];
    rd = fetch.instr[11:7];
    op = '0;
    rec = '0;

    if (fetch.valid) begin
      rec.pc = fetch.pc;
      rec.instr = fetch.instr;
      rec.waddr = rd;
      rec.raddr1 = fetch.instr[19:15];
      rec.raddr2 = fetch.instr[24:20];
      rec.caddr = fetch.instr[31:20];
      op.valid = 1'b1;

      case (opcode)
        opc_lui, opc_auipc: begin
          op.wren = 1'b1;
          rec.imm = {fetch.instr[31:12], 12'b0};
        end
        opc_jal: begin
          op.wren = 1'b1;
          rec.imm = {{12{sign}}, fetch.instr[19:12], fetch.instr[20], fetch.instr[30:21], 1'b0};
        end
        opc_jalr, opc_load, opc_op_imm: begin
          op.rden1 = 1'b1;
          op.wren = 1'b1;
          rec.imm = {{21{sign}}, fetch.instr[30:20]};
        end
        opc_store: begin
          op.rden1 = 1'b1;
          op.rden2 = 1'b1;
          rec.imm = {{21{sign}}, fetch.instr[30:25], fetch.instr[11:7]};
        end
        opc_branch: begin
          op.rden1 = 1'b1;
          op.rden2 = 1'b1;
          rec.imm = {{20{sign}}, fetch.instr[7], fetch.instr[30:25], fetch.instr[11:8], 1'b0};
        end
        opc_op: begin
          op.rden1 = 1'b1;
          op.rden2 = 1'b1;
          op.wren = 1'b1;
          // M extension shares the OP opcode
          if (funct7 == 7'b0000001) begin
            op.mult = ~funct3[2];
            op.division = funct3[2];
          end
        end
        opc_misc_mem: begin
          op.fence = 1'b1;
        end
        opc_system: begin
          if (funct3 == 3'b000) begin
            op.mret = (fetch.instr == mret_word);
            op.wfi = (fetch.instr == wfi_word);
          end else begin
            op.csreg = 1'b1;
            // Immediate CSR forms carry zimm in the rs1 field
            op.rden1 = ~funct3[2];
            op.wren = 1'b1;
          end
        end
        default: begin
        end
      endcase

      op.wren = op.wren & (rd != '0);
      op.alu = ~(op.mult | op.division | op.csreg | op.fence | op.mret | op.wfi);
      rec.op = op;
    end
  end

endmodule

// ==== rtl/issue_buffer.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_buffer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   hold,
  input  issue_pkg::instr_rec_t  rec0,
  input  issue_pkg::instr_rec_t  rec1,
  output issue_pkg::issue_slot_t issue0,
  output issue_pkg::issue_slot_t issue1,
  output logic                   stall
);

  localparam int ptr_width = $clog2(`ISSUE_DEPTH);
  localparam int count_width = ptr_width + 1;
  localparam int half_depth = `ISSUE_DEPTH / 2;

  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [count_width-1:0] count_t;

  typedef struct packed {
    ptr_t wid;
    ptr_t rid;
    count_t count;
    logic stall;
  } reg_type;

  localparam reg_type init_reg = '{
    wid: '0,
    rid: '0,
    count: '0,
    stall: 1'b0
  };

  issue_pkg::instr_rec_t buffer [`ISSUE_DEPTH];
  issue_pkg::instr_rec_t buffer_reg [`ISSUE_DEPTH];
  issue_pkg::instr_rec_t cand0;
  issue_pkg::instr_rec_t cand1;
  logic single;
  logic dual;
  logic raw;
  logic [1:0] pass;
  reg_type r;
  reg_type v;

  function automatic issue_pkg::issue_slot_t to_slot(input issue_pkg::instr_rec_t rec);
    issue_pkg::issue_slot_t slot;
    slot.pc = rec.pc;
    slot.instr = rec.instr;
    slot.imm = rec.imm;
    slot.waddr = rec.waddr;
    slot.raddr1 = rec.raddr1;
    slot.raddr2 = rec.raddr2;
    slot.caddr = rec.caddr;
    slot.op = rec.op;
    return slot;
  endfunction

  always_comb begin
    buffer = buffer_reg;
    v = r;

    if (flush) begin
      v.count = '0;
      v.wid = '0;
      v.rid = '0;
    end else if (!r.stall) begin
      // Slot 1 may arrive valid without slot 0
      if (rec0.op.valid) begin
        buffer[v.wid] = rec0;
        v.wid = v.wid + 1'b1;
        v.count = v.count + 1'b1;
      end
      if (rec1.op.valid) begin
        buffer[v.wid] = rec1;
        v.wid = v.wid + 1'b1;
        v.count = v.count + 1'b1;
      end
    end

    // Candidates include this cycle's append so an empty queue passes through
    cand0 = (v.count != '0) ? buffer[v.rid] : '0;
    cand1 = (v.count > count_t'(1)) ? buffer[ptr_t'(v.rid + 1'b1)] : '0;

    single = cand0.op.fence | cand0.op.mret | cand0.op.wfi |
             cand1.op.fence | cand1.op.mret | cand1.op.wfi;

    dual = (cand0.op.mult & cand1.op.mult) |
           (cand0.op.division & cand1.op.division) |
           (cand0.op.csreg & cand1.op.csreg);

    // wren is already clear for rd = x0, so writes to x0 never split a pair
    raw = cand0.op.wren &
          ((cand1.op.rden1 & (cand1.raddr1 == cand0.waddr)) |
           (cand1.op.rden2 & (cand1.raddr2 == cand0.waddr)));

    if (single || dual || raw) begin
      pass = 2'd1;
    end else begin
      pass = 2'd2;
    end

    if (hold) begin
      pass = 2'd0;
    end

    if (v.count < count_t'(pass)) begin
      pass = v.count[1:0];
    end

    v.count = v.count - count_t'(pass);
    v.rid = v.rid + ptr_t'(pass);
    v.stall = (v.count > count_t'(half_depth));

    issue0 = (pass != 2'd0) ? to_slot(cand0) : '0;
    issue1 = (pass == 2'd2) ? to_slot(cand1) : '0;
  end

  assign stall = r.stall;

  always_ff @(posedge clock) begin
    buffer_reg <= buffer;
    if (!reset) begin
      r <= init_reg;
    end else begin
      r <= v;
    end
  end

  count_bound_a: assert property (
    @(posedge clock) disable iff (!reset)
    r.count <= count_t'(`ISSUE_DEPTH)
  ) else $error("issue buffer count above depth");

  // Issue is in order, so slot 1 alone would skip the older instruction
  issue_order_a: assert property (
    @(posedge clock) disable iff (!reset)
    issue1.op.valid |-> issue0.op.valid
  ) else $error("issue1 valid without issue0");

  // A stalled cycle leaves the write pointer where it was
  stall_accept_a: assert property (
    @(posedge clock) disable iff (!reset)
    (r.stall && !flush) |=> (r.wid == $past(r.wid))
  ) else $error("input accepted while stall was high");

endmodule

// ==== rtl/issue_pkg.sv ====
`include "issue_macros.svh"

package issue_pkg;

  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // Operation class of one decoded instruction
  typedef struct packed {
    logic valid;
    logic wren;
    logic rden1;
    logic rden2;
    logic mult;
    logic division;
    logic csreg;
    logic fence;
    logic mret;
    logic wfi;
    logic alu;
  } op_flags_t;

  // One instruction slot as offered by fetch
  typedef struct packed {
    logic valid;
    word_t pc;
    word_t instr;
  } fetch_slot_t;

  // Decoded record held in the issue buffer
  typedef struct packed {
    word_t pc;
    word_t instr;
    word_t imm;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    csr_addr_t caddr;
    op_flags_t op;
  } instr_rec_t;

  // Record as handed to execute
  typedef struct packed {
    word_t pc;
    word_t instr;
    word_t imm;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    csr_addr_t caddr;
    op_flags_t op;
  } issue_slot_t;

endpackage

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   hold,
  input  issue_pkg::fetch_slot_t fetch0,
  input  issue_pkg::fetch_slot_t fetch1,
  output issue_pkg::issue_slot_t issue0,
  output issue_pkg::issue_slot_t issue1,
  output logic                   stall
);

  issue_pkg::instr_rec_t rec0;
  issue_pkg::instr_rec_t rec1;

  instr_decode decode0_i (
    .fetch (fetch0),
    .rec   (rec0)
  );

  instr_decode decode1_i (
    .fetch (fetch1),
    .rec   (rec1)
  );

  // Both decoded records enter the queue in program order
  issue_buffer buffer_i (
    .clock  (clock),
    .reset  (reset),
    .flush  (flush),
    .hold   (hold),
    .rec0   (rec0),
    .rec1   (rec1),
    .issue0 (issue0),
    .issue1 (issue1),
    .stall  (stall)
  );

endmodule

// ==== tests/issue_stage_tb.sv ====
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage_tb;

  localparam int clock_period = 40;
  localparam int reset_cycles = 16;
  localparam int stim_cycles = 3000;
  localparam int drain_cycles = 16;
  localparam int watchdog_cycles = 4000;
  localparam int watchdog_ns = (reset_cycles + watchdog_cycles) * clock_period;

  logic clock;
  logic reset;
  logic flush;
  logic hold;
  issue_pkg::fetch_slot_t fetch0;
  issue_pkg::fetch_slot_t fetch1;
  issue_pkg::issue_slot_t issue0;
  issue_pkg::issue_slot_t issue1;
  logic stall;

  integer seed;
  issue_pkg::word_t next_pc;
  issue_pkg::issue_slot_t exp_q[$];
  logic model_stall;
  logic last_stall;

  issue_stage dut_i (
    .clock  (clock),
    .reset  (reset),
    .flush  (flush),
    .hold   (hold),
    .fetch0 (fetch0),
    .fetch1 (fetch1),
    .issue0 (issue0),
    .issue1 (issue1),
    .stall  (stall)
  );

  always #(clock_period / 2) clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_slot(input string name, input issue_pkg::issue_slot_t expected,
                            input issue_pkg::issue_slot_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_stall(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] stall expected %h actual %h", expected, actual);
      $display("Result: FAILED");
      $fatal(1, "stall mismatch");
    end
  endtask

  // Reference decode for the opcodes that the stimulus produces
  function automatic issue_pkg::issue_slot_t model_decode(input issue_pkg::fetch_slot_t f);
    issue_pkg::issue_slot_t s;
    logic [31:0] w;
    s = '0;
    w = f.instr;
    if (f.valid) begin
      s.pc = f.pc;
      s.instr = w;
      s.waddr = w[11:7];
      s.raddr1 = w[19:15];
      s.raddr2 = w[24:20];
      s.caddr = w[31:20];
      s.op.valid = 1'b1;
      case (w[6:0])
        7'h37: begin
          s.op.wren = 1'b1;
          s.imm = {w[31:12], 12'h000};
        end
        7'h13: begin
          s.op.rden1 = 1'b1;
          s.op.wren = 1'b1;
          s.imm = {{20{w[31]}}, w[31:20]};
        end
        7'h23: begin
          s.op.rden1 = 1'b1;
          s.op.rden2 = 1'b1;
          s.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        7'h33: begin
          s.op.rden1 = 1'b1;
          s.op.rden2 = 1'b1;
          s.op.wren = 1'b1;
          if (w[31:25] == 7'h01) begin
            s.op.mult = (w[14:12] < 3'd4);
            s.op.division = !s.op.mult;
          end
        end
        7'h0f: s.op.fence = 1'b1;
        7'h73: begin
          if (w[14:12] == 3'd0) begin
            s.op.mret = (w == 32'h30200073);
            s.op.wfi = (w == 32'h10500073);
          end else begin
            s.op.csreg = 1'b1;
            s.op.wren = 1'b1;
            s.op.rden1 = (w[14:12] < 3'd4);
          end
        end
        default: ;
      endcase
      if (s.waddr == 5'd0) begin
        s.op.wren = 1'b0;
      end
      s.op.alu = !(s.op.mult || s.op.division || s.op.csreg ||
                   s.op.fence || s.op.mret || s.op.wfi);
    end
    return s;
  endfunction

  // Registers stay in x0..x7 so hazards and rd = x0 come up often
  task automatic new_slot(output issue_pkg::fetch_slot_t slot);
    int unsigned kind;
    issue_pkg::reg_addr_t rd;
    issue_pkg::reg_addr_t rs1;
    issue_pkg::reg_addr_t rs2;
    logic [31:0] rnd;
    logic [11:0] imm;
    kind = $unsigned($random(seed)) % 10;
    rd = issue_pkg::reg_addr_t'($unsigned($random(seed)) % 8);
    rs1 = issue_pkg::reg_addr_t'($unsigned($random(seed)) % 8);
    rs2 = issue_pkg::reg_addr_t'($unsigned($random(seed)) % 8);
    rnd = $random(seed);
    imm = rnd[11:0];
    slot.valid = ($unsigned($random(seed)) % 4) != 0;
    slot.pc = next_pc;
    next_pc = next_pc + 32'd4;
    case (kind)
      0: slot.instr = {imm, rs1, 3'b000, rd, 7'b0010011};
      1: slot.instr = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      2: slot.instr = {imm, rnd[19:12], rd, 7'b0110111};
      3: slot.instr = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      4: slot.instr = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
      5: slot.instr = {7'b0000001, rs2, rs1, 3'b100, rd, 7'b0110011};
      6: slot.instr = {imm, rs1, 3'b001, rd, 7'b1110011};
      7: slot.instr = 32'h0ff0000f;
      8: slot.instr = 32'h30200073;
      default: slot.instr = 32'h10500073;
    endcase
  endtask

  task automatic model_step();
    issue_pkg::issue_slot_t d0;
    issue_pkg::issue_slot_t d1;
    issue_pkg::issue_slot_t c0;
    issue_pkg::issue_slot_t c1;
    issue_pkg::issue_slot_t exp0;
    issue_pkg::issue_slot_t exp1;
    logic single;
    logic dual;
    logic raw;
    int pass;
    check_stall(model_stall, stall);
    last_stall = model_stall;
    if (flush) begin
      exp_q.delete();
    end else if (!model_stall) begin
      d0 = model_decode(fetch0);
      d1 = model_decode(fetch1);
      if (d0.op.valid) exp_q.push_back(d0);
      if (d1.op.valid) exp_q.push_back(d1);
    end
    c0 = '0;
    c1 = '0;
    if (exp_q.size() > 0) c0 = exp_q[0];
    if (exp_q.size() > 1) c1 = exp_q[1];
    single = c0.op.fence || c0.op.mret || c0.op.wfi || c1.op.fence || c1.op.mret || c1.op.wfi;
    dual = (c0.op.mult && c1.op.mult) || (c0.op.division && c1.op.division) ||
           (c0.op.csreg && c1.op.csreg);
    raw = c0.op.wren && ((c1.op.rden1 && c1.raddr1 == c0.waddr) ||
                         (c1.op.rden2 && c1.raddr2 == c0.waddr));
    pass = (single || dual || raw) ? 1 : 2;
    if (hold) pass = 0;
    if (exp_q.size() < pass) pass = exp_q.size();
    exp0 = (pass >= 1) ? c0 : '0;
    exp1 = (pass == 2) ? c1 : '0;
    check_slot("issue0", exp0, issue0);
    check_slot("issue1", exp1, issue1);
    repeat (pass) void'(exp_q.pop_front());
    model_stall = (exp_q.size() > `ISSUE_DEPTH / 2);
  endtask

  // A pair offered while stall was high was not taken, so it is offered again
  task automatic drive_cycle(input logic random_mode);
    issue_pkg::fetch_slot_t s0;
    issue_pkg::fetch_slot_t s1;
    int unsigned pick;
    @(posedge clock);
    if (!last_stall) begin
      if (random_mode) begin
        new_slot(s0);
        new_slot(s1);
      end else begin
        s0 = '0;
        s1 = '0;
      end
      fetch0 <= s0;
      fetch1 <= s1;
    end
    pick = $unsigned($random(seed)) % 100;
    hold <= random_mode && (pick < 20);
    pick = $unsigned($random(seed)) % 100;
    flush <= random_mode && (pick < 3);
    @(negedge clock);
    model_step();
  endtask

  initial begin
    seed = 34;
    next_pc = 32'h0000_1000;
    model_stall = 1'b0;
    last_stall = 1'b0;
    clock = 1'b0;
    reset <= 1'b0;
    flush <= 1'b0;
    hold <= 1'b0;
    fetch0 <= '0;
    fetch1 <= '0;
    repeat (reset_cycles - 1) @(posedge clock);
    @(negedge clock);
    check_slot("issue0", '0, issue0);
    check_slot("issue1", '0, issue1);
    check_stall(1'b0, stall);
    @(posedge clock);
    reset <= 1'b1;
    repeat (stim_cycles) drive_cycle(1'b1);
    // Let everything still queued drain out with hold low
    repeat (drain_cycles) drive_cycle(1'b0);
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    abort_run("Watchdog expired before the stimulus finished");
  end

endmodule
